//--- flist.f
+incdir+.
rv_pkg.sv
rv_alu.sv
rv_regfile.sv
rv_decode.sv
rv_dmem.sv
rv_imem.sv
rv_core_top.sv
rv_core_sva.sv
tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_rv_core -f flist.f
./obj_dir/Vtb_rv_core 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log || ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation failed, see sim.log."
  exit 1
fi
echo "Simulation passed."

//--- rv_alu.sv
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  logic [63:0] a,
  input  logic [63:0] b,
  input  alu_op_e     op,
  input  logic        word_op,
  input  logic [63:0] cmp_a,
  input  logic [63:0] cmp_b,
  output logic [63:0] res,
  output logic        eq,
  output logic        lt,
  output logic        ltu
);

  logic [5:0] shamt;
  xword_t     full;

  assign shamt = word_op ? {1'b0, b[4:0]} : b[5:0];

  always_comb begin
    case (op)
      ALU_ADD:    full = a + b;
      ALU_SUB:    full = a - b;
      ALU_SLL:    full = a << shamt;
      ALU_SLT:    full = {63'd0, $signed(a) < $signed(b)};
      ALU_SLTU:   full = {63'd0, a < b};
      ALU_XOR:    full = a ^ b;
      ALU_SRL:    full = word_op ? {32'd0, a[31:0] >> shamt} : a >> shamt;
      ALU_SRA: begin
        if (word_op) full = {32'd0, $signed(a[31:0]) >>> shamt};
        else full = $signed(a) >>> shamt;
      end
      ALU_OR:     full = a | b;
      ALU_AND:    full = a & b;
      ALU_PASS_B: full = b;
      default:    full = '0;
    endcase
  end

  // W results keep the low word and sign-extend it.
  assign res = word_op ? {{32{full[31]}}, full[31:0]} : full;

  assign eq  = (cmp_a == cmp_b);
  assign lt  = $signed(cmp_a) < $signed(cmp_b);
  assign ltu = cmp_a < cmp_b;

endmodule

`default_nettype wire

//--- rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath and memory sizing.
`define XLEN        64
`define IMEM_WORDS  256
`define DMEM_WORDS  256
`define PC_INIT     64'h0000_0000_0000_0000
`define INST_LEN    4

// Major opcodes, bits [6:0] of the instruction.
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_BRANCH   7'b1100011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_IMM      7'b0010011
`define OP_IMM32    7'b0011011
`define OP          7'b0110011
`define OP_32       7'b0111011
`define OP_SYSTEM   7'b1110011

`define INST_EBREAK 32'h0010_0073  // The only SYSTEM encoding the core acts on.

`endif

//--- rv_core_sva.sv
`default_nettype none

module rv_core_sva import rv_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input logic    run,
  input commit_t commit,
  input logic    halted
);

  timeunit 1ns;
  timeprecision 1ps;

  // An EBREAK commit halts at its own edge, so nothing retires after it.
  halt_stops_commits: assert property (@(posedge clk) disable iff (!rst_n)
    (commit.valid && commit.halt) |=> (halted && !commit.valid))
    else $error("The core kept committing after an EBREAK commit.");

  halt_is_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted)
    else $error("Halted fell without a reset.");

  pc_holds_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !run |=> $stable(commit.pc))
    else $error("Pc moved while run was low.");

endmodule

`default_nettype wire

//--- rv_core_top.sv
`default_nettype none

`include "rv_consts.svh"

module rv_core_top import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        load_valid,
  input  logic [7:0]  load_addr,
  input  logic [31:0] load_data,
  input  logic        run,
  output commit_t     commit,
  output logic        halted
);

  logic [`XLEN-1:0] pc, pc4, next_pc, imm;
  logic [`XLEN-1:0] rdata1, rdata2, alu_a, alu_b, alu_res, mem_rdata, wb_data;
  logic [31:0]      inst;
  logic [4:0]       rd;
  logic             active, taken, eq, lt, ltu;
  ctrl_t            ctrl;

  assign active = run && !halted;
  assign rd     = inst[11:7];
  assign pc4    = pc + 64'(`INST_LEN);

  rv_imem imem_i (.clk, .load_valid(load_valid && !run), .load_addr, .load_data,
                  .pc, .inst);

  rv_decode decode_i (.inst, .ctrl, .imm);

  rv_regfile regfile_i (.clk, .rst_n, .rs1(inst[19:15]), .rs2(inst[24:20]), .rd,
                        .wen(ctrl.reg_wen && active), .wdata(wb_data), .rdata1, .rdata2);

  always_comb begin
    case (ctrl.a_sel)
      A_PC:    alu_a = pc;
      A_ZERO:  alu_a = '0;
      default: alu_a = rdata1;
    endcase
  end

  assign alu_b = (ctrl.b_sel == B_IMM) ? imm : rdata2;

  rv_alu alu_i (.a(alu_a), .b(alu_b), .op(ctrl.alu_op), .word_op(ctrl.word_op),
                .cmp_a(rdata1), .cmp_b(rdata2), .res(alu_res), .eq, .lt, .ltu);

  rv_dmem dmem_i (.clk, .addr(alu_res), .wdata(rdata2), .wen(ctrl.mem_wen && active),
                  .ren(ctrl.mem_ren), .width(ctrl.mem_width), .rdata(mem_rdata));

  always_comb begin
    case (ctrl.branch)
      BR_JUMP: taken = 1'b1;
      BR_EQ:   taken = eq;
      BR_NE:   taken = !eq;
      BR_LT:   taken = lt;
      BR_GE:   taken = !lt;
      BR_LTU:  taken = ltu;
      BR_GEU:  taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  // Clearing bit 0 is required for JALR and harmless for JAL and branches.
  assign next_pc = taken ? {alu_res[63:1], 1'b0} : pc4;

  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  wb_data = mem_rdata;
      WB_PC4:  wb_data = pc4;
      default: wb_data = alu_res;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= `PC_INIT;
      halted <= 1'b0;
    end else if (active) begin
      pc <= next_pc;
      if (ctrl.ebreak) halted <= 1'b1;
    end
  end

  assign commit.valid   = active;
  assign commit.pc      = pc;
  assign commit.inst    = inst;
  assign commit.rd      = rd;
  assign commit.rd_wen  = ctrl.reg_wen;
  assign commit.rd_data = (ctrl.reg_wen && rd != 5'd0) ? wb_data : '0;  // Matches the x0 rule.
  assign commit.next_pc = next_pc;
  assign commit.halt    = ctrl.ebreak;

endmodule

`default_nettype wire

//--- rv_decode.sv
`default_nettype none

`include "rv_consts.svh"

module rv_decode import rv_pkg::*; (
  input  logic [31:0] inst,
  output ctrl_t       ctrl,
  output logic [63:0] imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt;
  logic       legal;
  ctrl_t      c;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign alt    = inst[30];

  // Shared funct3 mapping of OP, OP-IMM and their W forms.
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic sub_sra);
    case (f3)
      3'b000:  return sub_sra ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return sub_sra ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    c     = '0;
    legal = 1'b1;
    imm   = {{52{inst[31]}}, inst[31:20]};  // I-type unless the format says otherwise.
    case (opcode)
      `OP_LUI, `OP_AUIPC: begin
        imm       = {{32{inst[31]}}, inst[31:12], 12'b0};
        c.reg_wen = 1'b1;
        c.b_sel   = B_IMM;
        c.a_sel   = (opcode == `OP_LUI) ? A_ZERO : A_PC;
        c.alu_op  = (opcode == `OP_LUI) ? ALU_PASS_B : ALU_ADD;
      end
      `OP_JAL, `OP_JALR: begin
        if (opcode == `OP_JAL) begin
          imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        legal     = (opcode == `OP_JAL) || (funct3 == 3'b000);
        c.reg_wen = 1'b1;
        c.wb_sel  = WB_PC4;
        c.a_sel   = (opcode == `OP_JAL) ? A_PC : A_RS1;
        c.b_sel   = B_IMM;
        c.branch  = BR_JUMP;
      end
      `OP_BRANCH: begin
        imm     = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        c.a_sel = A_PC;
        c.b_sel = B_IMM;
        case (funct3)
          3'b000:  c.branch = BR_EQ;
          3'b001:  c.branch = BR_NE;
          3'b100:  c.branch = BR_LT;
          3'b101:  c.branch = BR_GE;
          3'b110:  c.branch = BR_LTU;
          3'b111:  c.branch = BR_GEU;
          default: legal = 1'b0;
        endcase
      end
      `OP_LOAD: begin
        legal       = (funct3 != 3'b111);
        c.reg_wen   = 1'b1;
        c.mem_ren   = 1'b1;
        c.wb_sel    = WB_MEM;
        c.b_sel     = B_IMM;
        c.mem_width = mem_width_e'(funct3);
      end
      `OP_STORE: begin
        imm         = {{52{inst[31]}}, inst[31:25], inst[11:7]};
        legal       = !funct3[2];
        c.mem_wen   = 1'b1;
        c.b_sel     = B_IMM;
        c.mem_width = mem_width_e'(funct3);
      end
      `OP_IMM, `OP_IMM32: begin
        c.word_op = (opcode == `OP_IMM32);
        c.reg_wen = 1'b1;
        c.b_sel   = B_IMM;
        c.alu_op  = alu_from_f3(funct3, (funct3 == 3'b101) && alt);
        if (funct3 == 3'b001) begin
          legal = c.word_op ? (funct7 == 7'b0) : (inst[31:26] == 6'b0);
        end else if (funct3 == 3'b101) begin
          legal = c.word_op ? (funct7 == 7'b0 || funct7 == 7'b0100000) :
                              (inst[31:26] == 6'b0 || inst[31:26] == 6'b010000);
        end else begin
          legal = !c.word_op || (funct3 == 3'b000);
        end
      end
      `OP, `OP_32: begin
        c.word_op = (opcode == `OP_32);
        c.reg_wen = 1'b1;
        c.alu_op  = alu_from_f3(funct3, alt);
        legal     = (funct7 == 7'b0) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        if (c.word_op && !(funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101)) begin
          legal = 1'b0;
        end
      end
      `OP_SYSTEM: begin
        c.ebreak = (inst == `INST_EBREAK);  // ECALL and the rest fall through as no-ops.
      end
      default: legal = 1'b0;
    endcase
    ctrl = legal ? c : '0;
  end

endmodule

`default_nettype wire

//--- rv_dmem.sv
`default_nettype none

`include "rv_consts.svh"

module rv_dmem import rv_pkg::*; (
  input  logic        clk,
  input  logic [63:0] addr,
  input  logic [63:0] wdata,
  input  logic        wen,
  input  logic        ren,
  input  mem_width_e  width,
  output logic [63:0] rdata
);

  localparam int AW = $clog2(`DMEM_WORDS);

  xword_t         mem [`DMEM_WORDS];
  logic [AW-1:0]  idx;
  logic [5:0]     bit_off;
  logic [7:0]     size_mask;
  logic [7:0]     byte_en;
  xword_t         wshift;
  xword_t         raw;

  assign idx     = addr[AW+2:3];
  assign bit_off = {addr[2:0], 3'b000};

  always_comb begin
    case (width)
      MW_B, MW_BU: size_mask = 8'h01;
      MW_H, MW_HU: size_mask = 8'h03;
      MW_W, MW_WU: size_mask = 8'h0f;
      default:     size_mask = 8'hff;
    endcase
  end

  assign byte_en = size_mask << addr[2:0];
  assign wshift  = wdata << bit_off;

  always_ff @(posedge clk) begin
    for (int i = 0; i < 8; i++) begin
      if (wen && byte_en[i]) mem[idx][i*8 +: 8] <= wshift[i*8 +: 8];
    end
  end

  assign raw = mem[idx] >> bit_off;  // Addressed field now sits at bit 0.

  always_comb begin
    case (width)
      MW_B:    rdata = {{56{raw[7]}}, raw[7:0]};
      MW_H:    rdata = {{48{raw[15]}}, raw[15:0]};
      MW_W:    rdata = {{32{raw[31]}}, raw[31:0]};
      MW_BU:   rdata = {56'd0, raw[7:0]};
      MW_HU:   rdata = {48'd0, raw[15:0]};
      MW_WU:   rdata = {32'd0, raw[31:0]};
      default: rdata = raw;
    endcase
    if (!ren) rdata = '0;
  end

endmodule

`default_nettype wire

//--- rv_imem.sv
`default_nettype none

`include "rv_consts.svh"

module rv_imem import rv_pkg::*; (
  input  logic        clk,
  input  logic        load_valid,
  input  logic [7:0]  load_addr,
  input  logic [31:0] load_data,
  input  logic [63:0] pc,
  output logic [31:0] inst
);

  localparam int AW = $clog2(`IMEM_WORDS);

  inst_word_t mem [`IMEM_WORDS];

  always_ff @(posedge clk) begin
    if (load_valid) mem[load_addr] <= load_data;
  end

  assign inst = mem[pc[AW+1:2]];  // Word index, the low two pc bits are ignored.

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

  typedef logic [`XLEN-1:0] xword_t;
  typedef logic [31:0] inst_word_t;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_e;
  typedef enum logic [0:0] {B_RS2, B_IMM} b_sel_e;
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

  // Order follows funct3 of the load and store encodings.
  typedef enum logic [2:0] {MW_B, MW_H, MW_W, MW_D, MW_BU, MW_HU, MW_WU} mem_width_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_JUMP, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } branch_e;

  typedef struct packed {
    alu_op_e    alu_op;
    a_sel_e     a_sel;
    b_sel_e     b_sel;
    wb_sel_e    wb_sel;
    logic       reg_wen;
    logic       mem_wen;
    logic       mem_ren;
    mem_width_e mem_width;
    branch_e    branch;
    logic       word_op;   // RV64 W variant.
    logic       ebreak;
  } ctrl_t;

  typedef struct packed {
    logic             valid;
    logic [63:0]      pc;
    logic [31:0]      inst;
    logic [4:0]       rd;
    logic             rd_wen;
    logic [63:0]      rd_data;
    logic [63:0]      next_pc;
    logic             halt;
  } commit_t;

endpackage

`default_nettype wire

//--- rv_regfile.sv
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        wen,
  input  logic [63:0] wdata,
  output logic [63:0] rdata1,
  output logic [63:0] rdata2
);

  xword_t regs [32];

  // No writes land while reset is asserted.
  always_ff @(posedge clk) begin
    if (rst_n && wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- rv_testdata.hex
// Program: word count, then instruction words from pc 0 upward.
// Records: count, then per line pc, rd, rd_wen, rd_data, next_pc.
30
FFB00093 00300113 800001B7 00001217 401102B3 4020D333 0020D3B3 0020A433
0020B4B3 0020853B 402185BB 01F1161B 04B03023 04102223 04201123 045000A3
04000683 04004703 04401783 04405803 04402883 04406903 04003983 00208463
00210463 FFF00F93 00211463 00209463 FFF00F93 00114463 0020C463 FFF00F93
0020D463 00115463 FFF00F93 0020E463 00116463 FFF00F93 00117463 0020F463
FFF00F93 00800A6F FFF00F93 00DA0AE7 FFF00F93 00708013 00200B33 00100073
28
00 01 1 FFFFFFFFFFFFFFFB 04
04 02 1 0000000000000003 08
08 03 1 FFFFFFFF80000000 0C
0C 04 1 000000000000100C 10
10 05 1 0000000000000008 14
14 06 1 FFFFFFFFFFFFFFFF 18
18 07 1 1FFFFFFFFFFFFFFF 1C
1C 08 1 0000000000000001 20
20 09 1 0000000000000000 24
24 0A 1 FFFFFFFFFFFFFFFE 28
28 0B 1 000000007FFFFFFD 2C
2C 0C 1 FFFFFFFF80000000 30
30 00 0 0000000000000000 34
34 04 0 0000000000000000 38
38 02 0 0000000000000000 3C
3C 01 0 0000000000000000 40
40 0D 1 FFFFFFFFFFFFFFFD 44
44 0E 1 00000000000000FD 48
48 0F 1 FFFFFFFFFFFFFFFB 4C
4C 10 1 000000000000FFFB 50
50 11 1 FFFFFFFFFFFFFFFB 54
54 12 1 00000000FFFFFFFB 58
58 13 1 FFFFFFFB000308FD 5C
5C 08 0 0000000000000000 60
60 08 0 0000000000000000 68
68 08 0 0000000000000000 6C
6C 08 0 0000000000000000 74
74 08 0 0000000000000000 78
78 08 0 0000000000000000 80
80 08 0 0000000000000000 84
84 08 0 0000000000000000 8C
8C 08 0 0000000000000000 90
90 08 0 0000000000000000 98
98 08 0 0000000000000000 9C
9C 08 0 0000000000000000 A4
A4 14 1 00000000000000A8 AC
AC 15 1 00000000000000B0 B4
B4 00 1 0000000000000000 B8
B8 16 1 0000000000000003 BC
BC 00 0 0000000000000000 C0

//--- tb_rv_core.sv
`default_nettype none

`include "rv_consts.svh"

module tb_rv_core
  import rv_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TD_WORDS     = 512;
  localparam int STEP_TIMEOUT = 50;  // Cycles allowed for any single wait.
  localparam int WATCH_CYCLES = 20;

  logic        clk;
  logic        rst_n;
  logic        load_valid;
  logic [7:0]  load_addr;
  logic [31:0] load_data;
  logic        run;
  commit_t     commit;
  logic        halted;

  // Program length, program words, record count, then five words per commit record.
  logic [63:0] tdata [TD_WORDS];
  int          prog_len;
  int          rec_count;

  rv_core_top dut_i (
    .clk(clk),
    .rst_n(rst_n),
    .load_valid(load_valid),
    .load_addr(load_addr),
    .load_data(load_data),
    .run(run),
    .commit(commit),
    .halted(halted)
  );

  bind rv_core_top rv_core_sva sva_i (
    .clk(clk),
    .rst_n(rst_n),
    .run(run),
    .commit(commit),
    .halted(halted)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns period.

  task automatic abort_test(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  function automatic string commit_text(input commit_t c);
    return $sformatf("valid=%b pc=%h inst=%h rd=%0d wen=%b data=%h next=%h halt=%b",
                     c.valid, c.pc, c.inst, c.rd, c.rd_wen, c.rd_data, c.next_pc, c.halt);
  endfunction

  task automatic check_commit(input string name, input commit_t exp, input commit_t act);
    if (act !== exp) begin
      abort_test($sformatf("[FAIL] %s expected {%s} actual {%s}", name,
                           commit_text(exp), commit_text(act)));
    end
  endtask

  task automatic check_halt(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_test($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
    end
  endtask

  // The instruction word comes from the program image at the record's pc.
  function automatic commit_t expected_commit(input int base, input logic last);
    commit_t c;
    c.valid   = 1'b1;
    c.pc      = tdata[base];
    c.inst    = tdata[1 + int'(tdata[base]) / `INST_LEN][31:0];
    c.rd      = tdata[base + 1][4:0];
    c.rd_wen  = tdata[base + 2][0];
    c.rd_data = tdata[base + 3];
    c.next_pc = tdata[base + 4];
    c.halt    = last;  // Only the closing EBREAK halts.
    return c;
  endfunction

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(posedge clk);
      load_valid <= 1'b1;
      load_addr  <= 8'(i);
      load_data  <= tdata[1 + i][31:0];
    end
    @(posedge clk);
    load_valid <= 1'b0;
  endtask

  task automatic wait_for_commit(input int idx);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > STEP_TIMEOUT) begin
        abort_test($sformatf("Timeout: commit %0d did not appear within %0d cycles.",
                             idx, STEP_TIMEOUT));
      end
    end while (commit.valid !== 1'b1);
  endtask

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (halted !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > STEP_TIMEOUT) begin
        abort_test("Timeout: the core did not halt after the EBREAK commit.");
      end
    end
  endtask

  initial begin
    commit_t exp;
    rst_n      = 1'b0;
    run        = 1'b0;
    load_valid = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    $readmemh("rv_testdata.hex", tdata);
    prog_len  = int'(tdata[0]);
    rec_count = int'(tdata[prog_len + 1]);
    if (prog_len < 1 || prog_len > `IMEM_WORDS || rec_count < 1) begin
      abort_test("The test data file has a bad program length or record count.");
    end

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    load_program();

    @(negedge clk);
    check_halt("halted low after reset", 1'b0, halted);
    check_halt("no commit before run", 1'b0, commit.valid);

    @(posedge clk);
    run <= 1'b1;
    for (int i = 0; i < rec_count; i++) begin
      exp = expected_commit(prog_len + 2 + 5 * i, i == rec_count - 1);
      wait_for_commit(i);
      check_commit($sformatf("commit %0d at pc %h", i, exp.pc), exp, commit);
    end

    wait_for_halt();
    for (int i = 0; i < WATCH_CYCLES; i++) begin
      check_halt("halted stays high", 1'b1, halted);
      check_halt("no commit after halt", 1'b0, commit.valid);
      @(negedge clk);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
